// ==== Makefile ====
# Verilator build and run for the miniCore testbench
TOP       ?= core_tb
LOG       ?= sim.log
OBJDIR    ?= obj_dir
VERILATOR ?= verilator
FILELIST  ?= sources.f
VFLAGS    ?= --binary --assert -j 0

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== source/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and pc width
`define CORE_XLEN 32

// architectural register file
`define CORE_REG_COUNT 32
`define CORE_REG_ADDR_W 5

// debug port write enable, one bit per byte lane
`define CORE_WEN_W 4

`endif

// ==== source/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;        // data or pc value
    typedef logic [31:0] instr_t;                 // raw instruction word
    typedef logic [`CORE_REG_ADDR_W-1:0] regAddr_t;
    typedef logic [3:0] aluOp_t;

    // alu operation codes
    localparam aluOp_t ALU_ADD = 4'd0;
    localparam aluOp_t ALU_SUB = 4'd1;
    localparam aluOp_t ALU_AND = 4'd2;
    localparam aluOp_t ALU_OR  = 4'd3;
    localparam aluOp_t ALU_XOR = 4'd4;
    localparam aluOp_t ALU_SLT = 4'd5;
    localparam aluOp_t ALU_LUI = 4'd6;            // passes operand b through

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // r-type funct field, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// ==== source/decodeStage.sv ====
module decodeStage (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               stall_i,
    input  logic               instrValid_i,
    input  core_pkg::instr_t   instr_i,
    input  core_pkg::word_t    pc_i,
    input  logic               wbWe_i,
    input  core_pkg::regAddr_t wbAddr_i,
    input  core_pkg::word_t    wbData_i,
    input  logic               exFwdValid_i,
    input  core_pkg::regAddr_t exFwdAddr_i,
    input  core_pkg::word_t    exFwdData_i,
    input  logic               rsFwdValid_i,
    input  core_pkg::regAddr_t rsFwdAddr_i,
    input  core_pkg::word_t    rsFwdData_i,
    output logic               valid_o,
    output core_pkg::word_t    pc_o,
    output core_pkg::aluOp_t   aluOp_o,
    output core_pkg::word_t    opA_o,
    output core_pkg::word_t    opB_o,
    output logic               regWrite_o,
    output core_pkg::regAddr_t dest_o
);
    import core_pkg::*;

    instr_t   instrQ;
    logic     validQ;
    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t rsAddr;
    regAddr_t rtAddr;
    word_t    rfDataA;
    word_t    rfDataB;
    word_t    imm;
    logic     useImm;
    logic     known;             // opcode in the supported subset
    logic     exHitA, exHitB;
    logic     rsHitA, rsHitB;
    word_t    rtValue;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            validQ <= 1'b0;
        end else if (!stall_i) begin
            validQ <= instrValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            instrQ <= instr_i;
            pc_o   <= pc_i;
        end
    end

    assign opcode = instrQ[31:26];
    assign funct  = instrQ[5:0];
    assign rsAddr = instrQ[25:21];
    assign rtAddr = instrQ[20:16];

    always_comb begin
        aluOp_o = ALU_ADD;
        dest_o  = instrQ[15:11];                          // rd for r-type
        imm     = {{16{instrQ[15]}}, instrQ[15:0]};
        useImm  = 1'b0;
        known   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                known = 1'b1;
                case (funct)
                    FN_ADDU: aluOp_o = ALU_ADD;
                    FN_SUBU: aluOp_o = ALU_SUB;
                    FN_AND:  aluOp_o = ALU_AND;
                    FN_OR:   aluOp_o = ALU_OR;
                    FN_XOR:  aluOp_o = ALU_XOR;
                    FN_SLT:  aluOp_o = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                known  = 1'b1;
                useImm = 1'b1;
                dest_o = rtAddr;
            end
            OP_ORI: begin
                known   = 1'b1;
                useImm  = 1'b1;
                aluOp_o = ALU_OR;
                dest_o  = rtAddr;
                imm     = {16'b0, instrQ[15:0]};        // zero extended
            end
            OP_LUI: begin
                known   = 1'b1;
                useImm  = 1'b1;
                aluOp_o = ALU_LUI;
                dest_o  = rtAddr;
                imm     = {instrQ[15:0], 16'b0};
            end
            default: known = 1'b0;
        endcase
    end

    assign valid_o    = validQ;
    assign regWrite_o = validQ & known & (dest_o != '0);

    registerFile u_registerFile (
        .clk(clk), .rst_i(rst_i),
        .we_i(wbWe_i), .wAddr_i(wbAddr_i), .wData_i(wbData_i),
        .rAddrA_i(rsAddr), .rAddrB_i(rtAddr),
        .rDataA_o(rfDataA), .rDataB_o(rfDataB)
    );

    // execute beats result, $0 never forwards
    assign exHitA = exFwdValid_i && (exFwdAddr_i == rsAddr) && (rsAddr != '0);
    assign exHitB = exFwdValid_i && (exFwdAddr_i == rtAddr) && (rtAddr != '0);
    assign rsHitA = rsFwdValid_i && (rsFwdAddr_i == rsAddr) && (rsAddr != '0);
    assign rsHitB = rsFwdValid_i && (rsFwdAddr_i == rtAddr) && (rtAddr != '0);

    assign opA_o   = exHitA ? exFwdData_i : (rsHitA ? rsFwdData_i : rfDataA);
    assign rtValue = exHitB ? exFwdData_i : (rsHitB ? rsFwdData_i : rfDataB);
    assign opB_o   = useImm ? imm : rtValue;

endmodule

// ==== source/executeStage.sv ====
module executeStage (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               stall_i,
    input  logic               valid_i,
    input  core_pkg::word_t    pc_i,
    input  core_pkg::aluOp_t   aluOp_i,
    input  core_pkg::word_t    opA_i,
    input  core_pkg::word_t    opB_i,
    input  logic               regWrite_i,
    input  core_pkg::regAddr_t dest_i,
    output logic               valid_o,
    output core_pkg::word_t    pc_o,
    output logic               regWrite_o,
    output core_pkg::regAddr_t dest_o,
    output core_pkg::word_t    aluResult_o
);
    import core_pkg::*;

    aluOp_t aluOpQ;
    word_t  opAQ;
    word_t  opBQ;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o    <= 1'b0;
            regWrite_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o    <= valid_i;
            regWrite_o <= regWrite_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_o   <= pc_i;
            aluOpQ <= aluOp_i;
            opAQ   <= opA_i;
            opBQ   <= opB_i;
            dest_o <= dest_i;
        end
    end

    // also feeds the execute forward path into decode
    always_comb begin
        case (aluOpQ)
            ALU_ADD: aluResult_o = opAQ + opBQ;
            ALU_SUB: aluResult_o = opAQ - opBQ;
            ALU_AND: aluResult_o = opAQ & opBQ;
            ALU_OR:  aluResult_o = opAQ | opBQ;
            ALU_XOR: aluResult_o = opAQ ^ opBQ;
            ALU_SLT: aluResult_o = word_t'($signed(opAQ) < $signed(opBQ));
            ALU_LUI: aluResult_o = opBQ;                  // immediate already shifted
            default: aluResult_o = '0;
        endcase
    end

endmodule

// ==== source/miniCore.sv ====
`include "core_config.svh"

module miniCore (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   instrValid_i,
    input  core_pkg::instr_t       instr_i,
    input  core_pkg::word_t        pc_i,
    output core_pkg::word_t        debugWbPc_o,
    output logic [`CORE_WEN_W-1:0] debugWbRfWen_o,
    output core_pkg::regAddr_t     debugWbRfWnum_o,
    output core_pkg::word_t        debugWbRfWdata_o
);
    import core_pkg::*;

    // decode to execute
    logic     decValid, decRegWrite;
    word_t    decPc, decOpA, decOpB;
    aluOp_t   decAluOp;
    regAddr_t decDest;
    // execute to result, and the execute forward path
    logic     exValid, exRegWrite;
    word_t    exPc, exResult;
    regAddr_t exDest;
    // write-back, doubles as the result forward path
    logic     wbWe, rsFwdValid;
    regAddr_t wbAddr;
    word_t    wbData;

    decodeStage u_decode (
        .clk(clk), .rst_i(rst_i), .stall_i(stall_i),
        .instrValid_i(instrValid_i), .instr_i(instr_i), .pc_i(pc_i),
        .wbWe_i(wbWe), .wbAddr_i(wbAddr), .wbData_i(wbData),
        .exFwdValid_i(exRegWrite), .exFwdAddr_i(exDest), .exFwdData_i(exResult),
        .rsFwdValid_i(rsFwdValid), .rsFwdAddr_i(wbAddr), .rsFwdData_i(wbData),
        .valid_o(decValid), .pc_o(decPc), .aluOp_o(decAluOp), .opA_o(decOpA),
        .opB_o(decOpB), .regWrite_o(decRegWrite), .dest_o(decDest)
    );

    executeStage u_execute (
        .clk(clk), .rst_i(rst_i), .stall_i(stall_i),
        .valid_i(decValid), .pc_i(decPc), .aluOp_i(decAluOp), .opA_i(decOpA),
        .opB_i(decOpB), .regWrite_i(decRegWrite), .dest_i(decDest),
        .valid_o(exValid), .pc_o(exPc), .regWrite_o(exRegWrite), .dest_o(exDest),
        .aluResult_o(exResult)
    );

    resultStage u_result (
        .clk(clk), .rst_i(rst_i), .stall_i(stall_i),
        .valid_i(exValid), .pc_i(exPc), .regWrite_i(exRegWrite), .dest_i(exDest),
        .result_i(exResult),
        .wbWe_o(wbWe), .wbAddr_o(wbAddr), .wbData_o(wbData), .fwdValid_o(rsFwdValid),
        .debugWbPc_o(debugWbPc_o), .debugWbRfWen_o(debugWbRfWen_o),
        .debugWbRfWnum_o(debugWbRfWnum_o), .debugWbRfWdata_o(debugWbRfWdata_o)
    );

endmodule

// ==== source/registerFile.sv ====
`include "core_config.svh"

module registerFile (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              we_i,
    input  core_pkg::regAddr_t wAddr_i,
    input  core_pkg::word_t   wData_i,
    input  core_pkg::regAddr_t rAddrA_i,
    input  core_pkg::regAddr_t rAddrB_i,
    output core_pkg::word_t   rDataA_o,
    output core_pkg::word_t   rDataB_o
);
    import core_pkg::*;

    word_t regs [`CORE_REG_COUNT];

    // write at the edge, $0 is never written
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wAddr_i != '0)) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // asynchronous read, no write-through
    // a same-cycle write reaches decode over the result forward path
    assign rDataA_o = (rAddrA_i == '0) ? '0 : regs[rAddrA_i];
    assign rDataB_o = (rAddrB_i == '0) ? '0 : regs[rAddrB_i];

endmodule

// ==== source/resultStage.sv ====
`include "core_config.svh"

module resultStage (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     stall_i,
    input  logic                     valid_i,
    input  core_pkg::word_t          pc_i,
    input  logic                     regWrite_i,
    input  core_pkg::regAddr_t       dest_i,
    input  core_pkg::word_t          result_i,
    output logic                     wbWe_o,
    output core_pkg::regAddr_t       wbAddr_o,
    output core_pkg::word_t          wbData_o,
    output logic                     fwdValid_o,
    output core_pkg::word_t          debugWbPc_o,
    output logic [`CORE_WEN_W-1:0]   debugWbRfWen_o,
    output core_pkg::regAddr_t       debugWbRfWnum_o,
    output core_pkg::word_t          debugWbRfWdata_o
);
    import core_pkg::*;

    logic  validQ;
    logic  regWriteQ;
    word_t pcQ;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            validQ    <= 1'b0;
            regWriteQ <= 1'b0;
        end else if (!stall_i) begin
            validQ    <= valid_i;
            regWriteQ <= regWrite_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pcQ      <= pc_i;
            wbAddr_o <= dest_i;
            wbData_o <= result_i;
        end
    end

    assign fwdValid_o = validQ & regWriteQ;               // forwards even while stalled
    assign wbWe_o     = fwdValid_o & ~stall_i;

    assign debugWbPc_o      = pcQ;
    assign debugWbRfWen_o   = {`CORE_WEN_W{wbWe_o}};
    assign debugWbRfWnum_o  = wbAddr_o;
    assign debugWbRfWdata_o = wbData_o;

endmodule

// ==== sources.f ====
+incdir+source
source/core_pkg.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/miniCore.sv
tests/core_sva.sv
tests/core_tb.sv

// ==== tests/core_sva.sv ====
`include "core_config.svh"

module core_sva (
    input logic                   clk,
    input logic                   rst_i,
    input logic                   stall_i,
    input logic [`CORE_WEN_W-1:0] debugWbRfWen_o,
    input core_pkg::regAddr_t     debugWbRfWnum_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // first reset edge still sees power-up state
    quietInReset: assert property (@(posedge clk) rst_i && $past(rst_i) |-> debugWbRfWen_o == '0)
        else $error("debug write enable set during reset");

    quietInStall: assert property (@(posedge clk) stall_i |-> debugWbRfWen_o == '0)
        else $error("debug write enable set while stalled");

    wenAllOrNone: assert property (@(posedge clk) disable iff (rst_i)
        debugWbRfWen_o == '0 || debugWbRfWen_o == '1)
        else $error("debug write enable is neither all zero nor all one");

    noWriteToZero: assert property (@(posedge clk) disable iff (rst_i)
        debugWbRfWen_o != '0 |-> debugWbRfWnum_o != '0)
        else $error("debug write-back names register zero");

endmodule

bind miniCore core_sva u_sva (
    .clk(clk), .rst_i(rst_i), .stall_i(stall_i),
    .debugWbRfWen_o(debugWbRfWen_o), .debugWbRfWnum_o(debugWbRfWnum_o)
);

// ==== tests/core_tb.sv ====
`include "core_config.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    logic clk, rst_i, stall_i, instrValid_i;
    instr_t instr_i;
    word_t pc_i, debugWbPc_o, debugWbRfWdata_o;
    logic [`CORE_WEN_W-1:0] debugWbRfWen_o;
    regAddr_t debugWbRfWnum_o;

    word_t modelRegs [`CORE_REG_COUNT];
    word_t expPc [$];
    word_t expData [$];
    regAddr_t expNum [$];
    int expEdge [$];                 // edge that took the instruction
    int edgeCount, errors, testsPassed, testsFailed;
    logic checkLatency;
    word_t nextPc;
    logic [15:0] lfsr;

    miniCore dut (
        .clk(clk), .rst_i(rst_i), .stall_i(stall_i), .instrValid_i(instrValid_i),
        .instr_i(instr_i), .pc_i(pc_i), .debugWbPc_o(debugWbPc_o),
        .debugWbRfWen_o(debugWbRfWen_o), .debugWbRfWnum_o(debugWbRfWnum_o),
        .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    always #50 clk = ~clk;

    // write-back monitor, outputs are settled before the edge
    always @(posedge clk) begin
        edgeCount = edgeCount + 1;
        if (!rst_i && stall_i && debugWbRfWen_o != '0) begin
            errors++;
            $display("%0t: write-back shown while stall_i is high", $time);
        end
        if (!rst_i && debugWbRfWen_o != '0) begin
            if (expNum.size() == 0) begin
                errors++;
                $display("%0t: unexpected write-back to register %0d", $time, debugWbRfWnum_o);
            end else begin
                if (debugWbPc_o !== expPc[0]) begin
                    errors++;
                    $display("Mismatch at %0t: debugWbPc_o expected %h got %h",
                             $time, expPc[0], debugWbPc_o);
                end
                if (debugWbRfWnum_o !== expNum[0]) begin
                    errors++;
                    $display("Mismatch at %0t: debugWbRfWnum_o expected %0d got %0d",
                             $time, expNum[0], debugWbRfWnum_o);
                end
                if (debugWbRfWdata_o !== expData[0]) begin
                    errors++;
                    $display("Mismatch at %0t: debugWbRfWdata_o expected %h got %h",
                             $time, expData[0], debugWbRfWdata_o);
                end
                if (checkLatency && edgeCount - expEdge[0] != 3) begin
                    errors++;
                    $display("%0t: write-back came %0d edges after issue instead of 3",
                             $time, edgeCount - expEdge[0]);
                end
                void'(expPc.pop_front());
                void'(expNum.pop_front());
                void'(expData.pop_front());
                void'(expEdge.pop_front());
            end
        end
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        repeat (n) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic instr_t rType(input logic [5:0] fn, input int rd, input int rs,
                                     input int rt);
        return {OP_RTYPE, regAddr_t'(rs), regAddr_t'(rt), regAddr_t'(rd), 5'd0, fn};
    endfunction

    function automatic instr_t iType(input logic [5:0] op, input int rt, input int rs,
                                     input int imm);
        return {op, regAddr_t'(rs), regAddr_t'(rt), 16'(imm)};
    endfunction

    // reference model, runs in program order at issue
    task automatic modelIssue(input instr_t ins);
        word_t a, b, r;
        regAddr_t dst;
        logic wr;
        a = modelRegs[ins[25:21]];
        b = modelRegs[ins[20:16]];
        dst = ins[20:16];
        wr = 1'b1;
        r = '0;
        case (ins[31:26])
            OP_RTYPE: begin
                dst = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: r = a + b;
                    FN_SUBU: r = a - b;
                    FN_AND:  r = a & b;
                    FN_OR:   r = a | b;
                    FN_XOR:  r = a ^ b;
                    FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: r = a + {{16{ins[15]}}, ins[15:0]};
            OP_ORI:   r = a | {16'h0, ins[15:0]};
            OP_LUI:   r = {ins[15:0], 16'h0};
            default:  wr = 1'b0;
        endcase
        if (wr && dst != '0) begin
            modelRegs[dst] = r;
            expPc.push_back(nextPc);
            expNum.push_back(dst);
            expData.push_back(r);
            expEdge.push_back(edgeCount + 1);
        end
    endtask

    task automatic drive(input logic stall, input logic valid, input instr_t ins);
        stall_i = stall;
        instrValid_i = valid;
        instr_i = ins;
        pc_i = nextPc;
    endtask

    // hold the instruction through the stalled edges, then let it go
    task automatic issue(input instr_t ins, input int stallCycles, input int gap);
        repeat (stallCycles) begin
            @(negedge clk);
            drive(1'b1, 1'b1, ins);
        end
        @(negedge clk);
        drive(1'b0, 1'b1, ins);
        modelIssue(ins);
        nextPc = nextPc + 4;
        repeat (gap) begin
            @(negedge clk);
            drive(1'b0, 1'b0, '0);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        drive(1'b0, 1'b0, '0);
        while (expNum.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (expNum.size() != 0) begin
            errors++;
            $display("%0t: timed out with %0d write-backs missing", $time, expNum.size());
            expPc.delete();
            expNum.delete();
            expData.delete();
            expEdge.delete();
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        if (errors == errBefore) begin
            testsPassed++;
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: FAIL with %0d errors", name, errors - errBefore);
        end
    endtask

    task automatic resetTest();
        int errBefore;
        errBefore = errors;
        rst_i = 1'b1;
        drive(1'b0, 1'b1, rType(FN_ADDU, 7, 0, 0));   // valid instruction held through reset
        repeat (5) begin
            @(negedge clk);
            if (debugWbRfWen_o !== '0) begin
                errors++;
                $display("%0t: write enable set during reset", $time);
            end
        end
        rst_i = 1'b0;
        drive(1'b0, 1'b0, '0);
        @(negedge clk);
        if (debugWbRfWen_o !== '0) begin
            errors++;
            $display("%0t: write enable set right after reset", $time);
        end
        issue(rType(FN_ADDU, 3, 1, 2), 0, 0);     // cleared registers give zero
        issue(rType(FN_OR, 4, 5, 6), 0, 0);
        drain();
        finishTest("reset", errBefore);
    endtask

    task automatic aluTest();
        int errBefore;
        errBefore = errors;
        checkLatency = 1'b1;
        issue(iType(OP_ADDIU, 1, 0, 'hfff6), 0, 0);   // -10
        issue(iType(OP_ADDIU, 2, 0, 7), 0, 0);
        issue(iType(OP_LUI, 3, 0, 'h1234), 0, 0);
        issue(iType(OP_ORI, 3, 3, 'h5678), 0, 0);
        issue(rType(FN_ADDU, 4, 1, 2), 0, 0);
        issue(rType(FN_SUBU, 5, 1, 2), 0, 0);
        issue(rType(FN_AND, 6, 1, 3), 0, 0);
        issue(rType(FN_OR, 7, 1, 3), 0, 0);
        issue(rType(FN_XOR, 8, 1, 3), 0, 0);
        issue(rType(FN_SLT, 9, 1, 2), 0, 0);
        issue(rType(FN_SLT, 10, 2, 1), 0, 0);
        issue(iType(OP_ORI, 11, 0, 'h8001), 0, 0);    // zero extended
        issue(iType(OP_ADDIU, 12, 0, 'h8001), 0, 0);  // sign extended
        drain();
        checkLatency = 1'b0;
        finishTest("alu", errBefore);
    endtask

    task automatic forwardTest();
        int errBefore;
        errBefore = errors;
        issue(iType(OP_ADDIU, 13, 0, 1), 0, 0);
        repeat (5) issue(rType(FN_ADDU, 13, 13, 13), 0, 0);
        issue(iType(OP_ADDIU, 14, 13, 3), 0, 1);
        issue(rType(FN_SUBU, 15, 14, 13), 0, 1);
        issue(rType(FN_XOR, 16, 15, 14), 0, 2);
        issue(rType(FN_SLT, 17, 16, 15), 0, 0);
        drain();
        finishTest("forwarding", errBefore);
    endtask

    task automatic stallTest();
        int errBefore;
        errBefore = errors;
        for (int i = 0; i < 8; i++) begin
            issue(iType(OP_ADDIU, 20 + i, 19 + i, 'h11 * i), (i == 4) ? 4 : 0, 0);
        end
        drain();
        finishTest("stall", errBefore);
    endtask

    task automatic noWriteTest();
        int errBefore;
        errBefore = errors;
        issue(rType(FN_ADDU, 0, 1, 2), 0, 0);
        issue(iType(OP_ADDIU, 0, 1, 5), 0, 0);
        issue(iType(6'h3f, 5, 1, 'h1234), 0, 0);     // opcode outside the subset
        issue(rType(6'h00, 6, 1, 2), 0, 0);          // funct outside the subset
        issue(rType(FN_ADDU, 18, 0, 0), 0, 0);
        issue(rType(FN_OR, 19, 0, 5), 0, 0);
        issue(rType(FN_OR, 20, 6, 0), 0, 0);
        drain();
        finishTest("no write", errBefore);
    endtask

    task automatic randomTest();
        int errBefore, kind, rd, rs, rt, imm, stallN, gapN;
        instr_t ins;
        errBefore = errors;
        repeat (200) begin
            kind = int'(randBits(4));
            rd = int'(randBits(3));                  // few registers, many hazards
            rs = int'(randBits(3));
            rt = int'(randBits(3));
            imm = int'(randBits(16));
            case (kind)
                0: ins = rType(FN_ADDU, rd, rs, rt);
                1: ins = rType(FN_SUBU, rd, rs, rt);
                2: ins = rType(FN_AND, rd, rs, rt);
                3: ins = rType(FN_OR, rd, rs, rt);
                4: ins = rType(FN_XOR, rd, rs, rt);
                5: ins = rType(FN_SLT, rd, rs, rt);
                6: ins = iType(OP_ORI, rd, rs, imm);
                7: ins = iType(OP_LUI, rd, rs, imm);
                8: ins = iType(6'h3f, rd, rs, imm);
                default: ins = iType(OP_ADDIU, rd, rs, imm);
            endcase
            stallN = (randBits(2) == 0) ? int'(randBits(2)) : 0;
            gapN = (randBits(2) == 0) ? 1 : 0;
            issue(ins, stallN, gapN);
        end
        drain();
        finishTest("random", errBefore);
    endtask

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        stall_i = 1'b0;
        instrValid_i = 1'b0;
        instr_i = '0;
        pc_i = '0;
        edgeCount = 0;
        errors = 0;
        testsPassed = 0;
        testsFailed = 0;
        checkLatency = 1'b0;
        nextPc = 32'hbfc0_0000;
        lfsr = 16'd31600;
        foreach (modelRegs[i]) modelRegs[i] = '0;
        resetTest();
        aluTest();
        forwardTest();
        stallTest();
        noWriteTest();
        randomTest();
        $display("tests passed %0d, failed %0d", testsPassed, testsFailed);
        if (errors == 0 && testsFailed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
